// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_xbar
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/addr_decoder.sv ====
// Request address decoder
module addr_decoder
   import xbar_pkg::*;
(
   // Initiator request
   input  req_t                 req_i,
   input  logic                 req_valid_i,
   output logic                 req_grant_o,
   // Target request, data shared by all ports
   output req_t                 tgt_req_o,
   output logic [N_TARGETS-1:0] tgt_valid_o,
   input  logic [N_TARGETS-1:0] tgt_grant_i,
   // Destination FIFO push side
   output port_t                dest_o,
   output logic                 dest_valid_o,
   input  logic                 dest_grant_i
);

   // Decoded target
   port_t port_sel;
   // Grant of the decoded target only
   logic  tgt_grant_sel;

   // Port field of the address
   assign port_sel = req_i.addr[PORT_SEL_LSB +: PORT_W];

   assign tgt_grant_sel = tgt_grant_i[port_sel];

   // One-hot target valid
   // Held off while the FIFO has no room for the port number
   always_comb
   begin
      tgt_valid_o           = '0;
      tgt_valid_o[port_sel] = req_valid_i & dest_grant_i;
   end

   // Request word goes out unchanged
   assign tgt_req_o = req_i;

   // Port number pushed in the same cycle as the request
   assign dest_o = port_sel;

   // FIFO grant closes the push handshake inside the FIFO
   assign dest_valid_o = req_valid_i & tgt_grant_sel;

   // Accepted only when target and FIFO both take it
   assign req_grant_o = tgt_grant_sel & dest_grant_i;

endmodule

// ==== logic/generic_fifo.sv ====
// Valid/grant FIFO
module generic_fifo
#(
   parameter int DATA_WIDTH = 32,
   parameter int DATA_DEPTH = 8
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Push side
   input  logic [DATA_WIDTH-1:0] data_i,
   input  logic                  valid_i,
   output logic                  grant_o,
   // Pop side
   output logic [DATA_WIDTH-1:0] data_o,
   output logic                  valid_o,
   input  logic                  grant_i
);

   // Pointer width, at least one bit
   localparam int PTR_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
   // Last slot index, pointers wrap here
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DATA_DEPTH - 1);

   typedef enum logic [1:0] {
      EMPTY,
      MIDDLE,
      FULL
   } state_t;

   state_t                 state_q, state_d;
   logic [PTR_W-1:0]       push_ptr_q, push_ptr_d;
   logic [PTR_W-1:0]       pop_ptr_q, pop_ptr_d;
   logic [PTR_W-1:0]       push_ptr_inc;
   logic [PTR_W-1:0]       pop_ptr_inc;
   logic [DATA_WIDTH-1:0]  fifo_mem [DATA_DEPTH];

   // Wrapping increments
   assign push_ptr_inc = (push_ptr_q == LAST_PTR) ? '0 : push_ptr_q + 1'b1;
   assign pop_ptr_inc  = (pop_ptr_q == LAST_PTR) ? '0 : pop_ptr_q + 1'b1;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= EMPTY;
         push_ptr_q <= '0;
         pop_ptr_q  <= '0;
      end
      else
      begin
         state_q    <= state_d;
         push_ptr_q <= push_ptr_d;
         pop_ptr_q  <= pop_ptr_d;
      end
   end

   // Next state, pointers and handshake outputs
   always_comb
   begin
      state_d    = state_q;
      push_ptr_d = push_ptr_q;
      pop_ptr_d  = pop_ptr_q;
      grant_o    = 1'b0;
      valid_o    = 1'b0;

      case (state_q)
         EMPTY:
         begin
            grant_o = 1'b1;
            // Nothing to pop, only a push matters
            if (valid_i)
            begin
               push_ptr_d = push_ptr_inc;
               state_d    = (push_ptr_inc == pop_ptr_q) ? FULL : MIDDLE;
            end
         end

         MIDDLE:
         begin
            grant_o = 1'b1;
            valid_o = 1'b1;
            case ({valid_i, grant_i})
               // Pop only
               2'b01:
               begin
                  pop_ptr_d = pop_ptr_inc;
                  if (pop_ptr_inc == push_ptr_q)
                     state_d = EMPTY;
               end
               // Push only
               2'b10:
               begin
                  push_ptr_d = push_ptr_inc;
                  if (push_ptr_inc == pop_ptr_q)
                     state_d = FULL;
               end
               // Push and pop, occupancy unchanged
               2'b11:
               begin
                  push_ptr_d = push_ptr_inc;
                  pop_ptr_d  = pop_ptr_inc;
               end
               default:
               begin
                  state_d = MIDDLE;
               end
            endcase
         end

         FULL:
         begin
            valid_o = 1'b1;
            // Push refused, wait for a pop
            if (grant_i)
            begin
               pop_ptr_d = pop_ptr_inc;
               state_d   = (pop_ptr_inc == push_ptr_q) ? EMPTY : MIDDLE;
            end
         end

         default:
         begin
            state_d = EMPTY;
         end
      endcase
   end

   // Storage, written on an accepted push
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < DATA_DEPTH; i++)
            fifo_mem[i] <= '0;
      end
      else if (grant_o && valid_i)
      begin
         fifo_mem[push_ptr_q] <= data_i;
      end
   end

   // Head entry
   assign data_o = fifo_mem[pop_ptr_q];

endmodule

// ==== logic/resp_mux.sv ====
// In-order response multiplexer
module resp_mux
   import xbar_pkg::*;
(
   // Destination FIFO pop side
   input  port_t                       head_port_i,
   input  logic                        head_valid_i,
   output logic                        head_pop_o,
   // Target responses
   input  resp_t [N_TARGETS-1:0]       tgt_resp_i,
   input  logic  [N_TARGETS-1:0]       tgt_resp_valid_i,
   output logic  [N_TARGETS-1:0]       tgt_resp_grant_o,
   // Initiator response
   output resp_t                       resp_o,
   output logic                        resp_valid_o,
   input  logic                        resp_grant_i
);

   // Only the oldest outstanding port may answer
   assign resp_o       = tgt_resp_i[head_port_i];
   assign resp_valid_o = head_valid_i & tgt_resp_valid_i[head_port_i];

   // Grant back to the head port alone
   // Other ports keep their responses until their turn
   always_comb
   begin
      tgt_resp_grant_o = '0;
      if (head_valid_i)
         tgt_resp_grant_o[head_port_i] = resp_grant_i;
   end

   // Accepted response retires the head entry
   assign head_pop_o = resp_valid_o & resp_grant_i;

endmodule

// ==== logic/xbar_demux_top.sv ====
// One-to-four request router
module xbar_demux_top
   import xbar_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Initiator request
   input  req_t                   req_i,
   input  logic                   req_valid_i,
   output logic                   req_grant_o,
   // Initiator response
   output resp_t                  resp_o,
   output logic                   resp_valid_o,
   input  logic                   resp_grant_i,
   // Target requests
   output req_t                   tgt_req_o,
   output logic  [N_TARGETS-1:0]  tgt_valid_o,
   input  logic  [N_TARGETS-1:0]  tgt_grant_i,
   // Target responses
   input  resp_t [N_TARGETS-1:0]  tgt_resp_i,
   input  logic  [N_TARGETS-1:0]  tgt_resp_valid_i,
   output logic  [N_TARGETS-1:0]  tgt_resp_grant_o
);

   // Push side of the destination FIFO
   port_t dest_port;
   logic  dest_valid;
   logic  dest_grant;

   // Pop side, port of the oldest request
   port_t head_port;
   logic  head_valid;
   logic  head_pop;

   addr_decoder i_addr_decoder (
      .req_i        (req_i),
      .req_valid_i  (req_valid_i),
      .req_grant_o  (req_grant_o),
      .tgt_req_o    (tgt_req_o),
      .tgt_valid_o  (tgt_valid_o),
      .tgt_grant_i  (tgt_grant_i),
      .dest_o       (dest_port),
      .dest_valid_o (dest_valid),
      .dest_grant_i (dest_grant)
   );

   // Port numbers of outstanding requests, oldest at the head
   generic_fifo #(
      .DATA_WIDTH (PORT_W),
      .DATA_DEPTH (DEST_DEPTH)
   ) i_dest_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_i  (dest_port),
      .valid_i (dest_valid),
      .grant_o (dest_grant),
      .data_o  (head_port),
      .valid_o (head_valid),
      .grant_i (head_pop)
   );

   resp_mux i_resp_mux (
      .head_port_i      (head_port),
      .head_valid_i     (head_valid),
      .head_pop_o       (head_pop),
      .tgt_resp_i       (tgt_resp_i),
      .tgt_resp_valid_i (tgt_resp_valid_i),
      .tgt_resp_grant_o (tgt_resp_grant_o),
      .resp_o           (resp_o),
      .resp_valid_o     (resp_valid_o),
      .resp_grant_i     (resp_grant_i)
   );

endmodule

// ==== logic/xbar_pkg.sv ====
// Request router shared definitions
package xbar_pkg;

   // Number of target ports behind the router
   localparam int N_TARGETS = 4;
   // Bits needed to name one target
   localparam int PORT_W = 2;

   // Initiator bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // Port field sits in address bits 13..12
   localparam int PORT_SEL_LSB = 12;

   // Max outstanding requests, set by destination FIFO size
   localparam int DEST_DEPTH = 4;

   // Port number type
   typedef logic [PORT_W-1:0] port_t;

   // Request word, broadcast to every target
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      // High for a write, low for a read
      logic              wen;
   } req_t;

   // Response word from a target
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
   } resp_t;

endpackage

// ==== tb.f ====
logic/xbar_pkg.sv
logic/generic_fifo.sv
logic/addr_decoder.sv
logic/resp_mux.sv
logic/xbar_demux_top.sv
tests/xbar_asserts.sv
tests/tb_xbar.sv

// ==== tests/tb_xbar.sv ====
// Request router testbench
module tb_xbar
   import xbar_pkg::*;
();

   // About four times the summed length of all tests
   localparam int TIMEOUT = 2000;
   localparam logic [31:0] LFSR_SEED = 32'h7452_bbed;
   // Response latency of each target model
   localparam int LAT [N_TARGETS] = '{6, 4, 2, 1};

   logic                  clk;
   logic                  rst_n;
   req_t                  req_i;
   logic                  req_valid_i;
   logic                  req_grant_o;
   resp_t                 resp_o;
   logic                  resp_valid_o;
   logic                  resp_grant_i;
   req_t                  tgt_req_o;
   logic [N_TARGETS-1:0]  tgt_valid_o;
   logic [N_TARGETS-1:0]  tgt_grant_i;
   resp_t [N_TARGETS-1:0] tgt_resp_i;
   logic [N_TARGETS-1:0]  tgt_resp_valid_i;
   logic [N_TARGETS-1:0]  tgt_resp_grant_o;

   int          cycle = 0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   logic [31:0] lfsr_q = LFSR_SEED;
   // Initiator grant control
   logic        hold_resp = 1'b0;
   logic        rand_grant = 1'b0;

   // Scoreboard in request order, plus the initiator's view of memory
   resp_t       exp_q [$];
   logic [31:0] ref_mem [logic [31:0]];
   // Target model state, memory keyed by port and address
   resp_t       data_q [N_TARGETS][$];
   int          due_q [N_TARGETS][$];
   logic [31:0] tgt_mem [logic [33:0]];

   xbar_demux_top i_xbar_demux_top (
      .clk              (clk),
      .rst_n            (rst_n),
      .req_i            (req_i),
      .req_valid_i      (req_valid_i),
      .req_grant_o      (req_grant_o),
      .resp_o           (resp_o),
      .resp_valid_o     (resp_valid_o),
      .resp_grant_i     (resp_grant_i),
      .tgt_req_o        (tgt_req_o),
      .tgt_valid_o      (tgt_valid_o),
      .tgt_grant_i      (tgt_grant_i),
      .tgt_resp_i       (tgt_resp_i),
      .tgt_resp_valid_i (tgt_resp_valid_i),
      .tgt_resp_grant_o (tgt_resp_grant_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic check_resp(input string name, input resp_t got, input resp_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_req(input string name, input req_t got, input req_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Port field lives in address bits 13..12
   function automatic req_t make_req(input port_t p, input logic [11:0] off,
                                     input logic wen, input logic [DATA_W-1:0] wdata);
      req_t r;
      r.addr  = {{(ADDR_W-PORT_SEL_LSB-PORT_W){1'b0}}, p, off};
      r.wdata = wdata;
      r.wen   = wen;
      return r;
   endfunction

   // Drive one request from a falling edge and wait for its handshake
   task automatic issue(input port_t p, input logic [11:0] off, input logic wen,
                        input logic [DATA_W-1:0] wdata);
      req_t  r;
      resp_t e;
      r           = make_req(p, off, wen, wdata);
      req_i       = r;
      req_valid_i = 1'b1;
      do
         @(posedge clk);
      while (!req_grant_o);
      // Accepted, only the intended port sees it
      check_req("tgt_req_o", tgt_req_o, r);
      for (int t = 0; t < N_TARGETS; t++)
         check_bit($sformatf("tgt_valid_o[%0d]", t), tgt_valid_o[t], t == int'(p));
      // Write echoes its data, read gets last write or address pattern
      if (r.wen)
      begin
         e.rdata          = r.wdata;
         ref_mem[r.addr]  = r.wdata;
      end
      else if (ref_mem.exists(r.addr))
         e.rdata = ref_mem[r.addr];
      else
         e.rdata = r.addr ^ 32'h5A5A_0000;
      exp_q.push_back(e);
      @(negedge clk);
      req_valid_i = 1'b0;
   endtask

   // Wait until every expected response came back
   task automatic drain();
      while (exp_q.size() != 0)
         @(posedge clk);
      @(negedge clk);
      check_bit("resp_valid_o", resp_valid_o, 1'b0);
   endtask

   // Grant mode changes after a rising edge
   task automatic set_grant(input logic hold, input logic rnd);
      @(posedge clk);
      hold_resp  = hold;
      rand_grant = rnd;
      @(negedge clk);
   endtask

   task automatic report(input string name, input int err0);
      tests_run++;
      if (errors != err0)
         tests_failed++;
      $display("%-22s %s", name, (errors == err0) ? "ok" : "FAIL");
   endtask

   task automatic reset_state();
      int err0;
      err0 = errors;
      check_bit("resp_valid_o", resp_valid_o, 1'b0);
      for (int t = 0; t < N_TARGETS; t++)
      begin
         check_bit($sformatf("tgt_valid_o[%0d]", t), tgt_valid_o[t], 1'b0);
         check_bit($sformatf("tgt_resp_grant_o[%0d]", t), tgt_resp_grant_o[t], 1'b0);
      end
      report("reset state", err0);
   endtask

   task automatic routing();
      int err0;
      err0 = errors;
      for (int p = 0; p < N_TARGETS; p++)
         issue(port_t'(p), 12'(16 * p), 1'b0, '0);
      drain();
      report("routing", err0);
   endtask

   task automatic in_order_return();
      int    err0;
      port_t order [4] = '{2'd0, 2'd3, 2'd2, 2'd1};
      err0 = errors;
      // Slow target first, faster ones must wait their turn
      for (int i = 0; i < 4; i++)
         issue(order[i], 12'h100, 1'b0, '0);
      drain();
      report("in-order return", err0);
   endtask

   task automatic req_backpressure();
      int err0;
      err0 = errors;
      set_grant(1'b1, 1'b0);
      for (int i = 0; i < DEST_DEPTH; i++)
         issue(port_t'(i), 12'h200, 1'b0, '0);
      // FIFO full, next request must stall
      req_i       = make_req(2'd1, 12'h204, 1'b0, '0);
      req_valid_i = 1'b1;
      repeat (10)
      begin
         @(posedge clk);
         check_bit("req_grant_o", req_grant_o, 1'b0);
      end
      set_grant(1'b0, 1'b0);
      issue(2'd1, 12'h204, 1'b0, '0);
      drain();
      report("request back-pressure", err0);
   endtask

   task automatic resp_backpressure();
      int err0;
      err0 = errors;
      set_grant(1'b0, 1'b1);
      // Write then read back the same word, pairs spread over ports
      for (int i = 0; i < 16; i++)
         issue(port_t'(i / 2), 12'(i / 2 * 4), (i % 2) == 0, 32'hC0DE_0000 + 32'(i));
      drain();
      set_grant(1'b0, 1'b0);
      report("response back-pressure", err0);
   endtask

   task automatic random_traffic();
      int          err0;
      port_t       p;
      logic [2:0]  word;
      logic        wen;
      logic [31:0] wd;
      err0 = errors;
      for (int i = 0; i < 64; i++)
      begin
         p    = port_t'(rand_bits(2));
         word = 3'(rand_bits(3));
         wen  = 1'(rand_bits(1));
         wd   = rand_bits(32);
         issue(p, {7'h0, word, 2'b00}, wen, wd);
      end
      drain();
      report("random traffic", err0);
   endtask

   // Target models accept, count latency and retire granted responses
   initial
   begin : target_accept
      logic [33:0] key;
      resp_t       rd;
      forever
      begin
         @(posedge clk);
         cycle = cycle + 1;
         for (int t = 0; t < N_TARGETS; t++)
         begin
            if (tgt_resp_valid_i[t] && tgt_resp_grant_o[t])
            begin
               data_q[t].delete(0);
               due_q[t].delete(0);
            end
            if (tgt_valid_o[t] && tgt_grant_i[t])
            begin
               key = {2'(t), tgt_req_o.addr};
               if (tgt_req_o.wen)
               begin
                  tgt_mem[key] = tgt_req_o.wdata;
                  rd.rdata     = tgt_req_o.wdata;
               end
               else if (tgt_mem.exists(key))
                  rd.rdata = tgt_mem[key];
               else
                  rd.rdata = tgt_req_o.addr ^ 32'h5A5A_0000;
               data_q[t].push_back(rd);
               due_q[t].push_back(cycle + LAT[t]);
            end
         end
      end
   end

   // Response valid held until granted
   initial
   begin
      tgt_resp_i       = '0;
      tgt_resp_valid_i = '0;
      forever
      begin
         @(negedge clk);
         for (int t = 0; t < N_TARGETS; t++)
         begin
            tgt_resp_valid_i[t] = (due_q[t].size() != 0) && (cycle >= due_q[t][0]);
            tgt_resp_i[t]       = (data_q[t].size() != 0) ? data_q[t][0] : '0;
         end
      end
   end

   // Initiator response grant
   initial
   begin
      resp_grant_i = 1'b1;
      forever
      begin
         @(negedge clk);
         if (hold_resp)
            resp_grant_i = 1'b0;
         else if (rand_grant)
            resp_grant_i = 1'(rand_bits(1));
         else
            resp_grant_i = 1'b1;
      end
   end

   // Every accepted response checked against the scoreboard head
   initial
   begin
      forever
      begin
         @(posedge clk);
         if (rst_n && resp_valid_o && resp_grant_i)
         begin
            if (exp_q.size() == 0)
            begin
               $display("Response returned while no request was outstanding");
               errors++;
            end
            else
               check_resp("resp_o", resp_o, exp_q.pop_front());
         end
      end
   end

   initial
   begin
      wait (cycle >= TIMEOUT);
      @(negedge clk);
      $display("Timeout after %0d cycles, the router stopped answering", cycle);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      rst_n       = 1'b0;
      req_i       = '0;
      req_valid_i = 1'b0;
      tgt_grant_i = '1;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      reset_state();
      routing();
      in_order_return();
      req_backpressure();
      resp_backpressure();
      random_traffic();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== tests/xbar_asserts.sv ====
// Router protocol assertions
module xbar_asserts
   import xbar_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input logic                 req_valid_i,
   input logic                 req_grant_o,
   input logic                 dest_valid,
   input logic                 dest_grant,
   input logic [N_TARGETS-1:0] tgt_valid_o,
   input resp_t                resp_o,
   input logic                 resp_valid_o,
   input logic                 resp_grant_i
);

   // Requests accepted and not yet answered
   int   outstanding;
   logic req_hs;
   logic resp_hs;

   assign req_hs  = req_valid_i && req_grant_o;
   assign resp_hs = resp_valid_o && resp_grant_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         outstanding <= 0;
      else
         outstanding <= outstanding + int'(req_hs) - int'(resp_hs);
   end

   // Destination FIFO takes no port number once every entry is in use
   full_no_push: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding == DEST_DEPTH |-> !(dest_valid && dest_grant))
      else $error("destination FIFO pushed with all entries in use");

   // Request steered to one target at most
   one_target: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(tgt_valid_o))
      else $error("more than one target valid");

   // Stalled response holds its word
   resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid_o && !resp_grant_i |=> resp_valid_o && $stable(resp_o))
      else $error("response changed while stalled");

endmodule

bind xbar_demux_top xbar_asserts i_xbar_asserts (
   .clk          (clk),
   .rst_n        (rst_n),
   .req_valid_i  (req_valid_i),
   .req_grant_o  (req_grant_o),
   .dest_valid   (dest_valid),
   .dest_grant   (dest_grant),
   .tgt_valid_o  (tgt_valid_o),
   .resp_o       (resp_o),
   .resp_valid_o (resp_valid_o),
   .resp_grant_i (resp_grant_i)
);
